//--- logic/l1_trigger_pkg.sv
package l1_trigger_pkg;

    //////////////////////////////////////////////////
    // Datapath sizes
    //////////////////////////////////////////////////
    localparam int NCHAN    = 8;    // Antenna channels after AGC
    localparam int NBEAMS   = 4;
    localparam int SAMP_W   = 5;    // Signed sample width
    localparam int SUM_W    = 8;    // Eight 5-bit samples never leave -128..120
    localparam int POWER_W  = 15;   // 128 squared still fits
    localparam int THRESH_W = 18;
    localparam int COUNT_W  = 32;

    // Beam steering, delay in samples per beam and channel
    localparam int MAX_DELAY = 3;
    localparam int unsigned BEAM_DELAY [NBEAMS][NCHAN] = '{
        '{0, 0, 0, 0, 0, 0, 0, 0},  // Boresight
        '{0, 0, 1, 1, 2, 2, 3, 3},  // Tilted towards channel 0
        '{3, 3, 2, 2, 1, 1, 0, 0},  // Mirror of beam 1
        '{0, 1, 2, 3, 0, 1, 2, 3}   // Fine step, repeated twice
    };

    // Trigger timing
    localparam int HOLDOFF_CLOCKS = 16;                          // Dead time after a trigger
    localparam int HOLD_W         = $clog2(HOLDOFF_CLOCKS + 1);
    localparam int RATE_CLOCKS    = 200;                         // Rate window length
    localparam int RATE_W         = $clog2(RATE_CLOCKS);

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////
    localparam int ADDR_W      = 12;
    localparam int DATA_W      = 32;
    localparam int REG_IDX_LSB = 2;                          // Word aligned registers
    localparam int BEAM_IDX_W  = $clog2(NBEAMS);
    localparam int BANK_LSB    = REG_IDX_LSB + BEAM_IDX_W;   // Lowest bit of a bank address

    localparam logic [ADDR_W-1:0] ADDR_CTRL        = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_THRESH_BASE = 12'h400;
    localparam logic [ADDR_W-1:0] ADDR_COUNT_BASE  = 12'h800;

    localparam int CTRL_START_BIT  = 0;  // Start a rate count
    localparam int CTRL_UPDATE_BIT = 1;  // Pending to active copy

    // Nothing can trigger until a real threshold is loaded
    localparam logic [THRESH_W-1:0] THRESH_RESET = {THRESH_W{1'b1}};

endpackage

//--- logic/beam_power.sv
`timescale 1ns/1ns

module beam_power import l1_trigger_pkg::*; (
    input  logic                            aclk,
    input  logic                            rst_n_i,
    input  logic [NCHAN-1:0][SAMP_W-1:0]    dat_i,          // Channel 0 in the low bits
    output logic [NBEAMS-1:0][POWER_W-1:0]  beam_power_o    // Valid two edges after the taps
);

    // tap_q[d][c] holds channel c as sampled d edges before the newest one
    logic        [SAMP_W-1:0] tap_q [0:MAX_DELAY][NCHAN];
    logic signed [SUM_W-1:0]  sum_d [NBEAMS];
    logic signed [SUM_W-1:0]  sum_q [NBEAMS];

    //////////////////////////////////////////////////
    // Delay lines
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            for (int d = 0; d <= MAX_DELAY; d++) begin
                for (int c = 0; c < NCHAN; c++) begin
                    tap_q[d][c] <= '0;
                end
            end
        end else begin
            for (int c = 0; c < NCHAN; c++) begin
                tap_q[0][c] <= dat_i[c];                // Newest sample, delay 0
            end
            for (int d = 1; d <= MAX_DELAY; d++) begin
                for (int c = 0; c < NCHAN; c++) begin
                    tap_q[d][c] <= tap_q[d-1][c];       // Shift one sample older
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Delayed channel sum
    //////////////////////////////////////////////////
    // Each beam picks its own tap per channel from the steering table
    always_comb begin
        for (int b = 0; b < NBEAMS; b++) begin
            sum_d[b] = '0;
            for (int c = 0; c < NCHAN; c++) begin
                // Sign extended into the sum width
                sum_d[b] = sum_d[b] + $signed(tap_q[BEAM_DELAY[b][c]][c]);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            for (int b = 0; b < NBEAMS; b++) begin
                sum_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NBEAMS; b++) begin
                sum_q[b] <= sum_d[b];                   // Stage 2
            end
        end
    end

    //////////////////////////////////////////////////
    // Beam power
    //////////////////////////////////////////////////
    // Square of a signed sum is never negative, the widest is (-128)^2
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            beam_power_o <= '0;
        end else begin
            for (int b = 0; b < NBEAMS; b++) begin
                beam_power_o[b] <= POWER_W'(sum_q[b] * sum_q[b]);   // Stage 3
            end
        end
    end

endmodule

//--- logic/threshold_bank.sv
`timescale 1ns/1ns

module threshold_bank import l1_trigger_pkg::*; (
    input  logic                             aclk,
    input  logic                             rst_n_i,
    input  logic                             reg_wr_i,          // One-cycle write strobe
    input  logic                             reg_rd_i,          // One-cycle read strobe
    input  logic [ADDR_W-1:0]                reg_addr_i,
    input  logic [DATA_W-1:0]                reg_wdata_i,
    input  logic [NBEAMS-1:0][COUNT_W-1:0]   trigger_counts_i,
    input  logic                             count_done_i,
    output logic [DATA_W-1:0]                reg_rdata_o,
    output logic                             reg_rvalid_o,
    output logic [NBEAMS-1:0][THRESH_W-1:0]  thresh_active_o,   // Thresholds in use
    output logic                             rate_start_o       // Pulse, one edge after the write
);

    logic                             ctrl_hit;
    logic                             thresh_hit;
    logic                             count_hit;
    logic [BEAM_IDX_W-1:0]            beam_sel;
    logic [NBEAMS-1:0][THRESH_W-1:0]  thresh_pend_q;    // Staged, not yet in use

    // Read pipeline
    logic                             rd_q;
    logic                             rd_ctrl_q;
    logic                             rd_thresh_q;
    logic                             rd_count_q;
    logic [BEAM_IDX_W-1:0]            rd_sel_q;
    logic [DATA_W-1:0]                rdata_d;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    assign ctrl_hit   = (reg_addr_i == ADDR_CTRL);
    assign thresh_hit = (reg_addr_i[ADDR_W-1:BANK_LSB] == ADDR_THRESH_BASE[ADDR_W-1:BANK_LSB])
                     && (reg_addr_i[REG_IDX_LSB-1:0] == '0);
    assign count_hit  = (reg_addr_i[ADDR_W-1:BANK_LSB] == ADDR_COUNT_BASE[ADDR_W-1:BANK_LSB])
                     && (reg_addr_i[REG_IDX_LSB-1:0] == '0);
    assign beam_sel   = reg_addr_i[REG_IDX_LSB +: BEAM_IDX_W];    // Word index inside a bank

    //////////////////////////////////////////////////
    // Writes
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            thresh_pend_q   <= {NBEAMS{THRESH_RESET}};
            thresh_active_o <= {NBEAMS{THRESH_RESET}};
            rate_start_o    <= 1'b0;
        end else begin
            rate_start_o <= reg_wr_i && ctrl_hit && reg_wdata_i[CTRL_START_BIT];

            if (reg_wr_i && thresh_hit) begin
                thresh_pend_q[beam_sel] <= reg_wdata_i[THRESH_W-1:0];  // Low 18 bits only
            end

            // All beams switch on the same edge
            if (reg_wr_i && ctrl_hit && reg_wdata_i[CTRL_UPDATE_BIT]) begin
                thresh_active_o <= thresh_pend_q;
            end
        end
    end

    //////////////////////////////////////////////////
    // Reads
    //////////////////////////////////////////////////
    // First stage holds the decoded request
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            rd_q        <= 1'b0;
            rd_ctrl_q   <= 1'b0;
            rd_thresh_q <= 1'b0;
            rd_count_q  <= 1'b0;
        end else begin
            rd_q        <= reg_rd_i;
            rd_ctrl_q   <= reg_rd_i && ctrl_hit;
            rd_thresh_q <= reg_rd_i && thresh_hit;
            rd_count_q  <= reg_rd_i && count_hit;
        end
    end

    always_ff @(posedge aclk) begin
        rd_sel_q <= beam_sel;
    end

    // Source select, the sources are sampled one edge after the strobe
    always_comb begin
        rdata_d = '0;                                       // Unmapped reads return zero
        if (rd_ctrl_q) begin
            rdata_d = DATA_W'(count_done_i);                // Status, done in bit 0
        end else if (rd_thresh_q) begin
            rdata_d = DATA_W'(thresh_pend_q[rd_sel_q]);     // Pending, not active
        end else if (rd_count_q) begin
            rdata_d = trigger_counts_i[rd_sel_q];
        end
    end

    // Second stage, data and valid leave together
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            reg_rvalid_o <= 1'b0;
        end else begin
            reg_rvalid_o <= rd_q;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_q) begin
            reg_rdata_o <= rdata_d;
        end
    end

endmodule

//--- logic/beam_trigger_rate.sv
`timescale 1ns/1ns

module beam_trigger_rate import l1_trigger_pkg::*; (
    input  logic                             aclk,
    input  logic                             rst_n_i,
    input  logic [NBEAMS-1:0][POWER_W-1:0]   beam_power_i,
    input  logic [NBEAMS-1:0][THRESH_W-1:0]  thresh_active_i,
    input  logic                             rate_start_i,       // Clears and opens the window
    output logic [NBEAMS-1:0]                trigger_o,
    output logic [NBEAMS-1:0][COUNT_W-1:0]   trigger_counts_o,
    output logic                             count_done_o
);

    logic [NBEAMS-1:0]              fire;           // Comparison result before the register
    logic [NBEAMS-1:0][HOLD_W-1:0]  holdoff_q;      // Clocks left in the dead time
    logic                           win_open_q;
    logic [RATE_W-1:0]              win_cnt_q;      // Edges left in the window, minus one
    logic                           win_close_q;    // Window closed on the last edge

    //////////////////////////////////////////////////
    // Threshold comparison
    //////////////////////////////////////////////////
    // Strictly greater, and only outside the holdoff
    always_comb begin
        for (int b = 0; b < NBEAMS; b++) begin
            fire[b] = (THRESH_W'(beam_power_i[b]) > thresh_active_i[b])
                   && (holdoff_q[b] == '0);
        end
    end

    //////////////////////////////////////////////////
    // Trigger register and holdoff
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            trigger_o <= '0;
            holdoff_q <= '0;
        end else begin
            trigger_o <= fire;                  // One edge after the power
            for (int b = 0; b < NBEAMS; b++) begin
                if (rate_start_i) begin
                    holdoff_q[b] <= '0;         // Fresh start for the count
                end else if (fire[b]) begin
                    holdoff_q[b] <= HOLD_W'(HOLDOFF_CLOCKS);
                end else if (holdoff_q[b] != '0) begin
                    holdoff_q[b] <= holdoff_q[b] - 1'b1;
                end
            end
        end
    end
    // Next fire is HOLDOFF_CLOCKS+1 edges after the last one

    //////////////////////////////////////////////////
    // Rate window
    //////////////////////////////////////////////////
    // Open for RATE_CLOCKS edges after the start edge
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            win_open_q   <= 1'b0;
            win_cnt_q    <= '0;
            win_close_q  <= 1'b0;
            count_done_o <= 1'b0;
        end else if (rate_start_i) begin
            win_open_q   <= 1'b1;               // Also restarts a running window
            win_cnt_q    <= RATE_W'(RATE_CLOCKS - 1);
            win_close_q  <= 1'b0;
            count_done_o <= 1'b0;
        end else begin
            win_close_q <= 1'b0;
            if (win_open_q) begin
                if (win_cnt_q == '0) begin
                    win_open_q  <= 1'b0;        // Last counted edge
                    win_close_q <= 1'b1;
                end else begin
                    win_cnt_q <= win_cnt_q - 1'b1;
                end
            end
            if (win_close_q) begin
                count_done_o <= 1'b1;           // Held until the next start
            end
        end
    end

    //////////////////////////////////////////////////
    // Trigger counters
    //////////////////////////////////////////////////
    // Counts the registered trigger_o, so every pulse seen outside is counted
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            trigger_counts_o <= '0;
        end else if (rate_start_i) begin
            trigger_counts_o <= '0;
        end else if (win_open_q) begin
            for (int b = 0; b < NBEAMS; b++) begin
                // Saturate at all ones
                if (trigger_o[b] && (trigger_counts_o[b] != '1)) begin
                    trigger_counts_o[b] <= trigger_counts_o[b] + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/l1_trigger.sv
`timescale 1ns/1ns

module l1_trigger import l1_trigger_pkg::*; (
    input  logic                          aclk,
    input  logic                          rst_n_i,
    input  logic [NCHAN-1:0][SAMP_W-1:0]  dat_i,          // One sample per channel per clock
    input  logic                          reg_wr_i,
    input  logic                          reg_rd_i,
    input  logic [ADDR_W-1:0]             reg_addr_i,
    input  logic [DATA_W-1:0]             reg_wdata_i,
    output logic [NBEAMS-1:0]             trigger_o,      // Three edges after the samples
    output logic [DATA_W-1:0]             reg_rdata_o,
    output logic                          reg_rvalid_o
);

    logic [NBEAMS-1:0][POWER_W-1:0]   beam_power_w;
    logic [NBEAMS-1:0][THRESH_W-1:0]  thresh_active_w;
    logic                             rate_start_w;
    logic [NBEAMS-1:0][COUNT_W-1:0]   trigger_counts_w;
    logic                             count_done_w;

    //////////////////////////////////////////////////
    // Beamformer and register bank side by side
    //////////////////////////////////////////////////
    beam_power u_beam_power (
        .aclk            (aclk),
        .rst_n_i         (rst_n_i),
        .dat_i           (dat_i),
        .beam_power_o    (beam_power_w)
    );

    threshold_bank u_threshold_bank (
        .aclk             (aclk),
        .rst_n_i          (rst_n_i),
        .reg_wr_i         (reg_wr_i),
        .reg_rd_i         (reg_rd_i),
        .reg_addr_i       (reg_addr_i),
        .reg_wdata_i      (reg_wdata_i),
        .trigger_counts_i (trigger_counts_w),   // Readback only
        .count_done_i     (count_done_w),
        .reg_rdata_o      (reg_rdata_o),
        .reg_rvalid_o     (reg_rvalid_o),
        .thresh_active_o  (thresh_active_w),
        .rate_start_o     (rate_start_w)
    );

    // Combines power and thresholds
    beam_trigger_rate u_beam_trigger_rate (
        .aclk             (aclk),
        .rst_n_i          (rst_n_i),
        .beam_power_i     (beam_power_w),
        .thresh_active_i  (thresh_active_w),
        .rate_start_i     (rate_start_w),
        .trigger_o        (trigger_o),
        .trigger_counts_o (trigger_counts_w),
        .count_done_o     (count_done_w)
    );

endmodule

//--- verification/l1_trigger_assert.sv
`timescale 1ns/1ns

module l1_trigger_assert import l1_trigger_pkg::*; (
    input  logic               aclk,
    input  logic               rst_n_i,
    input  logic [NBEAMS-1:0]  trigger_i,
    input  logic               rate_start_i,    // Clears every holdoff, so it may shorten one
    input  logic               reg_rd_i,
    input  logic               reg_rvalid_i
);

    int failures = 0;   // Failed assertion count

    //////////////////////////////////////////////////
    // Trigger dead time
    //////////////////////////////////////////////////
    for (genvar b = 0; b < NBEAMS; b++) begin : g_beam
        holdoff_a : assert property (@(posedge aclk) disable iff (!rst_n_i || rate_start_i)
            trigger_i[b] |=> (!trigger_i[b]) [*HOLDOFF_CLOCKS])
        else begin
            failures++;
            $error("Beam %0d triggered again inside its holdoff", b);
        end
    end

    // Nothing fires in reset or on the first clock after it
    reset_quiet_a : assert property (@(posedge aclk)
        !rst_n_i |=> (trigger_i == '0) ##1 (trigger_i == '0))
    else begin
        failures++;
        $error("Trigger seen during or right after reset");
    end

    //////////////////////////////////////////////////
    // Read timing
    //////////////////////////////////////////////////
    rvalid_follows_read_a : assert property (@(posedge aclk) disable iff (!rst_n_i)
        reg_rd_i |-> ##2 reg_rvalid_i)
    else begin
        failures++;
        $error("Read strobe not answered by a valid pulse");
    end

    rvalid_has_read_a : assert property (@(posedge aclk) disable iff (!rst_n_i)
        reg_rvalid_i |-> $past(reg_rd_i, 2))
    else begin
        failures++;
        $error("Valid pulse without a read strobe");
    end

    rvalid_width_a : assert property (@(posedge aclk) disable iff (!rst_n_i)
        reg_rvalid_i |=> !reg_rvalid_i)
    else begin
        failures++;
        $error("Valid pulse longer than one cycle");
    end

endmodule

bind l1_trigger l1_trigger_assert u_assert (
    .aclk         (aclk),
    .rst_n_i      (rst_n_i),
    .trigger_i    (trigger_o),
    .rate_start_i (rate_start_w),
    .reg_rd_i     (reg_rd_i),
    .reg_rvalid_i (reg_rvalid_o)
);

//--- verification/l1_trigger_tb.sv
`timescale 1ns/1ns

module l1_trigger_tb import l1_trigger_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int RAND_RUN    = 400;   // Cycles of random data in the trigger test
    localparam int HOLD_RUN    = 120;
    localparam int TEST_CYCLES = 150 + 240 + (RAND_RUN + 20) + HOLD_RUN
                               + (2 * RATE_CLOCKS + 150);
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;   // Margin for slow polling
    localparam int HIST_D      = 4 + MAX_DELAY;         // Three pipeline edges plus the taps

    logic                          aclk;
    logic                          rst_n_i;
    logic [NCHAN-1:0][SAMP_W-1:0]  dat_i;
    logic                          reg_wr_i;
    logic                          reg_rd_i;
    logic [ADDR_W-1:0]             reg_addr_i;
    logic [DATA_W-1:0]             reg_wdata_i;
    logic [NBEAMS-1:0]             trigger_o;
    logic [DATA_W-1:0]             reg_rdata_o;
    logic                          reg_rvalid_o;

    logic [31:0]        rng = 32'd96837;
    bit                 const_data = 1'b0;      // All channels at full scale when set
    string              test_name = "none";
    int                 err_count = 0;
    int                 test_err_start = 0;
    int                 checks = 0;
    int                 n_tests = 0;
    logic [DATA_W-1:0]  rdata;

    // Reference model state
    int                               m_hist [HIST_D][NCHAN];   // [k] sampled k edges ago
    int                               m_hold [NBEAMS];
    logic [NBEAMS-1:0]                m_trig = '0;
    logic [NBEAMS-1:0][THRESH_W-1:0]  m_pend;
    logic [NBEAMS-1:0][THRESH_W-1:0]  m_active;
    logic [NBEAMS-1:0][COUNT_W-1:0]   m_count;
    int                               m_edge = 0;
    int                               m_start = 0;    // Edge of the last start write
    bit                               m_started = 1'b0;
    bit                               m_start_pend = 1'b0;
    bit                               m_rd_pend = 1'b0;
    logic [DATA_W-1:0]                m_rd_data;
    logic [NBEAMS-1:0]                exp_trig = '0;
    bit                               exp_rvalid = 1'b0;
    logic [DATA_W-1:0]                exp_rdata;

    l1_trigger u_dut (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .dat_i        (dat_i),
        .reg_wr_i     (reg_wr_i),
        .reg_rd_i     (reg_rd_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .trigger_o    (trigger_o),
        .reg_rdata_o  (reg_rdata_o),
        .reg_rvalid_o (reg_rvalid_o)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Beam index of a word aligned bank address or -1 outside the bank
    function automatic int bank_index(input logic [ADDR_W-1:0] addr,
                                      input logic [ADDR_W-1:0] base);
        if (addr >= base && addr < base + 4 * NBEAMS && addr[1:0] == 2'b00) begin
            return (addr - base) / 4;
        end
        return -1;
    endfunction

    //////////////////////////////////////////////////
    // Reference model called once per rising edge
    //////////////////////////////////////////////////
    function automatic logic [NBEAMS-1:0] model_step(
        input logic rst_n, input logic [NCHAN-1:0][SAMP_W-1:0] dat, input logic wr,
        input logic rd, input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        logic [NBEAMS-1:0] fire;
        int                sum;
        int                tb;
        int                cb;
        bit                done;
        fire       = '0;
        exp_rvalid = m_rd_pend;                 // Read strobed one edge earlier answers now
        exp_rdata  = m_rd_data;
        if (!rst_n) begin
            foreach (m_hist[d, c]) m_hist[d][c] = 0;
            foreach (m_hold[b]) m_hold[b] = 0;
            m_pend       = {NBEAMS{THRESH_RESET}};
            m_active     = {NBEAMS{THRESH_RESET}};
            m_count      = '0;
            m_trig       = '0;
            m_started    = 1'b0;
            m_start_pend = 1'b0;
            m_rd_pend    = 1'b0;
            exp_rvalid   = 1'b0;
            return '0;
        end
        for (int d = HIST_D - 1; d > 0; d--) begin
            for (int c = 0; c < NCHAN; c++) m_hist[d][c] = m_hist[d-1][c];
        end
        for (int c = 0; c < NCHAN; c++) m_hist[0][c] = $signed(dat[c]);
        // Power behind this edge comes from samples three edges back plus the steering delay
        for (int b = 0; b < NBEAMS; b++) begin
            sum = 0;
            for (int c = 0; c < NCHAN; c++) sum += m_hist[3 + BEAM_DELAY[b][c]][c];
            fire[b] = (sum * sum > int'(m_active[b])) && (m_hold[b] == 0);
        end
        if (m_start_pend) begin                 // Start write one edge ago
            m_count   = '0;
            m_start   = m_edge - 1;
            m_started = 1'b1;
            foreach (m_hold[b]) m_hold[b] = 0;
        end else begin
            for (int b = 0; b < NBEAMS; b++) begin
                if (fire[b]) m_hold[b] = HOLDOFF_CLOCKS;
                else if (m_hold[b] > 0) m_hold[b]--;
            end
            if (m_started && m_edge >= m_start + 2 && m_edge <= m_start + RATE_CLOCKS + 1) begin
                for (int b = 0; b < NBEAMS; b++) begin
                    if (m_trig[b] && m_count[b] != '1) m_count[b]++;
                end
            end
        end
        // Register writes
        tb = bank_index(addr, ADDR_THRESH_BASE);
        cb = bank_index(addr, ADDR_COUNT_BASE);
        m_start_pend = wr && addr == ADDR_CTRL && wdata[0];
        if (wr && addr == ADDR_CTRL && wdata[1]) m_active = m_pend;
        if (wr && tb >= 0) m_pend[tb] = wdata[THRESH_W-1:0];
        // Read data from the state after this edge
        done      = m_started && m_edge >= m_start + RATE_CLOCKS + 2;
        m_rd_data = '0;
        if (addr == ADDR_CTRL) m_rd_data = DATA_W'(done);
        else if (tb >= 0) m_rd_data = DATA_W'(m_pend[tb]);
        else if (cb >= 0) m_rd_data = m_count[cb];
        m_rd_pend = rd;
        m_trig    = fire;
        m_edge++;
        return fire;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus and comparison
    //////////////////////////////////////////////////
    always @(posedge aclk) begin
        for (int c = 0; c < NCHAN; c++) begin
            rng = xorshift32(rng);
            dat_i[c] <= const_data ? SAMP_W'(15) : rng[SAMP_W-1:0];   // 15 is full scale
        end
    end

    // Outputs hold the last edge and inputs hold what the next edge samples
    always @(negedge aclk) begin
        checks++;
        assert (trigger_o === exp_trig) else begin
            err_count++;
            $display("Mismatch %s trigger_o expected %h actual %h",
                     test_name, exp_trig, trigger_o);
        end
        if (exp_rvalid) begin
            checks++;
            assert (reg_rvalid_o === 1'b1) else begin
                err_count++;
                $display("Read in test %s got no valid pulse on the expected cycle", test_name);
            end
            assert (reg_rdata_o === exp_rdata) else begin
                err_count++;
                $display("Mismatch %s reg_rdata_o expected %h actual %h",
                         test_name, exp_rdata, reg_rdata_o);
            end
        end else begin
            assert (reg_rvalid_o === 1'b0) else begin
                err_count++;
                $display("Valid pulse without a read in test %s", test_name);
            end
        end
        exp_trig = model_step(rst_n_i, dat_i, reg_wr_i, reg_rd_i, reg_addr_i, reg_wdata_i);
    end

    task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge aclk);
        reg_wr_i    <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge aclk);
        reg_wr_i    <= 1'b0;
    endtask

    task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int waited;
        @(posedge aclk);
        reg_rd_i   <= 1'b1;
        reg_addr_i <= addr;
        @(posedge aclk);
        reg_rd_i   <= 1'b0;
        waited = 0;
        do begin
            @(negedge aclk);
            waited++;
        end while (!reg_rvalid_o && waited < 4);    // Bounded wait for the valid pulse
        data = reg_rdata_o;
    endtask

    task automatic read_all_beams(input logic [ADDR_W-1:0] base);
        logic [DATA_W-1:0] data;
        for (int b = 0; b < NBEAMS; b++) reg_read(base + ADDR_W'(4 * b), data);
    endtask

    task automatic write_thresholds(input int first, input int step);
        for (int b = 0; b < NBEAMS; b++) begin
            // High bits are junk and must be dropped
            reg_write(ADDR_THRESH_BASE + ADDR_W'(4 * b), {14'h2A5, THRESH_W'(first + step * b)});
        end
    endtask

    // Polls the status register until the window closes
    task automatic wait_done();
        logic [DATA_W-1:0] status;
        int                tries;
        status = '0;
        tries  = 0;
        while (!status[0] && tries < RATE_CLOCKS) begin
            reg_read(ADDR_CTRL, status);
            tries++;
        end
        checks++;
        assert (status[0]) else begin
            err_count++;
            $display("Done flag never rose in test %s", test_name);
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        n_tests++;
        $display("Test %s finished with %0d errors", test_name, err_count - test_err_start);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    initial begin
        int total;
        rst_n_i     = 1'b0;
        dat_i       = '0;
        reg_wr_i    = 1'b0;
        reg_rd_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        repeat (10) @(posedge aclk);
        rst_n_i <= 1'b1;

        start_test("reset");
        read_all_beams(ADDR_THRESH_BASE);
        read_all_beams(ADDR_COUNT_BASE);
        reg_read(ADDR_CTRL, rdata);
        repeat (100) @(posedge aclk);           // Random data with all thresholds at maximum
        end_test();

        start_test("staged");
        write_thresholds(400, 150);             // Low values go to the pending set only
        read_all_beams(ADDR_THRESH_BASE);
        repeat (50) @(posedge aclk);
        reg_write(ADDR_CTRL, 32'h2);            // Pending to active
        repeat (150) @(posedge aclk);
        end_test();

        start_test("power");
        write_thresholds(900, 400);
        reg_write(ADDR_CTRL, 32'h2);
        repeat (RAND_RUN) @(posedge aclk);
        end_test();

        start_test("holdoff");
        const_data <= 1'b1;                     // Sum of 120 is far above every threshold
        repeat (HOLD_RUN) @(posedge aclk);
        const_data <= 1'b0;
        end_test();

        start_test("rate");
        reg_write(ADDR_CTRL, 32'h1);
        reg_read(ADDR_CTRL, rdata);             // Window still open
        wait_done();
        read_all_beams(ADDR_COUNT_BASE);
        reg_write(ADDR_CTRL, 32'h1);
        repeat (50) @(posedge aclk);
        reg_write(ADDR_CTRL, 32'h1);            // Restart inside a running window
        reg_read(ADDR_CTRL, rdata);
        read_all_beams(ADDR_COUNT_BASE);
        wait_done();
        read_all_beams(ADDR_COUNT_BASE);
        repeat (2) @(posedge aclk);             // Last read answer reaches the comparison
        end_test();

        total = err_count + u_dut.u_assert.failures;
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, total);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- tb.f
logic/l1_trigger_pkg.sv
logic/beam_power.sv
logic/threshold_bank.sv
logic/beam_trigger_rate.sv
logic/l1_trigger.sv
verification/l1_trigger_assert.sv
verification/l1_trigger_tb.sv

//--- Bender.yml
package:
  name: l1_trigger

sources:
  # RTL, package first
  - files:
      - logic/l1_trigger_pkg.sv
      - logic/beam_power.sv
      - logic/threshold_bank.sv
      - logic/beam_trigger_rate.sv
      - logic/l1_trigger.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verification/l1_trigger_assert.sv
      - verification/l1_trigger_tb.sv
